/* include/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// csr numbers
localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;

// exception codes
localparam logic [5:0] ecode_adef = 6'h08;  // fetch address error
localparam logic [5:0] ecode_ale  = 6'h09;  // misaligned load/store
localparam logic [5:0] ecode_sys  = 6'h0b;
localparam logic [5:0] ecode_ine  = 6'h0d;

// field positions
localparam int crmd_plv_lsb       = 0;   // 2 bits
localparam int crmd_ie_bit        = 2;
localparam int prmd_pplv_lsb      = 0;   // 2 bits
localparam int prmd_pie_bit       = 2;
localparam int estat_ecode_lsb    = 16;  // 6 bits
localparam int estat_esubcode_lsb = 22;  // 9 bits
localparam int eentry_va_lsb      = 6;

// field widths
localparam int plv_w      = 2;
localparam int ecode_w    = 6;
localparam int esubcode_w = 9;

`endif

/* src/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int xlen      = 32;
    localparam int csr_num_w = 14;

`include "csr_defs.svh"

    // software-writable bits per csr
    localparam logic [xlen-1:0] crmd_wmask   = 32'h0000_0007;  // plv, ie
    localparam logic [xlen-1:0] prmd_wmask   = 32'h0000_0007;  // pplv, pie
    localparam logic [xlen-1:0] estat_wmask  = 32'h0000_0003;  // sw interrupt bits
    localparam logic [xlen-1:0] era_wmask    = 32'hffff_ffff;
    localparam logic [xlen-1:0] badv_wmask   = 32'hffff_ffff;
    localparam logic [xlen-1:0] eentry_wmask = 32'hffff_ffc0;
    localparam logic [xlen-1:0] save_wmask   = 32'hffff_ffff;

    // item handed over from mem
    typedef struct packed {
        logic                 gr_we;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      inst;
        logic [xlen-1:0]      final_result;
        logic [4:0]           dest;
        logic                 csr_we;
        logic                 csr_re;
        logic [csr_num_w-1:0] csr_num;
        logic [xlen-1:0]      csr_wmask;
        logic [xlen-1:0]      csr_wvalue;
        logic                 ertn;
        logic                 ex;
        logic [xlen-1:0]      wrong_addr;
        logic [8:0]           esubcode;
        logic [5:0]           ecode;
    } mem_wb_bus_t;

    // forwarding back to decode
    typedef struct packed {
        logic            rf_we;
        logic [4:0]      rf_waddr;
        logic [xlen-1:0] rf_wdata;
        logic            csr_re;
    } wb_fwd_t;

    typedef struct packed {
        logic [csr_num_w-1:0] num;
        logic                 re;
        logic                 we;
        logic [xlen-1:0]      wvalue;
        logic [xlen-1:0]      wmask;
    } csr_req_t;

    // exception entry / return
    typedef struct packed {
        logic            ex;
        logic            ertn;
        logic [xlen-1:0] pc;
        logic [5:0]      ecode;
        logic [8:0]      esubcode;
        logic [xlen-1:0] wrong_addr;
    } wb_event_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [3:0]      rf_we;
        logic [4:0]      rf_wnum;
        logic [xlen-1:0] rf_wdata;
    } trace_t;

endpackage

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

module reg_file import wb_pkg::*; (
    input  wire             clk,

    input  wire             we,
    input  wire [4:0]       waddr,
    input  wire [xlen-1:0]  wdata,

    input  wire [4:0]       raddr1,
    output logic [xlen-1:0] rdata1,

    input  wire [4:0]       raddr2,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin  // r0 is never written
            regs[waddr] <= wdata;
        end
    end

    // async read ports, r0 hardwired to zero
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

/* src/csr_file.sv */
`default_nettype none

module csr_file import wb_pkg::*; (
    input  wire             clk,
    input  wire             resetn,
    input  wire csr_req_t   csr_req,
    input  wire wb_event_t  wb_event,
    output logic [xlen-1:0] csr_rvalue,
    output logic [xlen-1:0] redirect_pc
);

    logic [xlen-1:0] crmd;
    logic [xlen-1:0] prmd;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] era;
    logic [xlen-1:0] badv;
    logic [xlen-1:0] eentry;
    logic [xlen-1:0] save0;
    logic [xlen-1:0] save1;
    logic [xlen-1:0] save2;
    logic [xlen-1:0] save3;
    logic            badv_hit;

    // new bits under mask, old bits elsewhere
    function automatic logic [xlen-1:0] blend(
        input logic [xlen-1:0] old_v,
        input logic [xlen-1:0] new_v,
        input logic [xlen-1:0] req_mask,
        input logic [xlen-1:0] writable
    );
        logic [xlen-1:0] m;
        m = req_mask & writable;
        return (old_v & ~m) | (new_v & m);
    endfunction

    // only address faults latch badv
    assign badv_hit = (wb_event.ecode == ecode_adef) || (wb_event.ecode == ecode_ale);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd   <= '0;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
            save0  <= '0;
            save1  <= '0;
            save2  <= '0;
            save3  <= '0;
        end else if (wb_event.ex) begin
            prmd[prmd_pplv_lsb +: plv_w] <= crmd[crmd_plv_lsb +: plv_w];
            prmd[prmd_pie_bit]           <= crmd[crmd_ie_bit];
            crmd[crmd_plv_lsb +: plv_w]  <= '0;    // enter kernel
            crmd[crmd_ie_bit]            <= 1'b0;  // interrupts off
            era <= wb_event.pc;
            estat[estat_ecode_lsb +: ecode_w]       <= wb_event.ecode;
            estat[estat_esubcode_lsb +: esubcode_w] <= wb_event.esubcode;
            if (badv_hit) begin
                badv <= wb_event.wrong_addr;
            end
        end else if (wb_event.ertn) begin
            crmd[crmd_plv_lsb +: plv_w] <= prmd[prmd_pplv_lsb +: plv_w];
            crmd[crmd_ie_bit]           <= prmd[prmd_pie_bit];
        end else if (csr_req.we) begin
            case (csr_req.num)
                csr_crmd: begin
                    crmd <= blend(crmd, csr_req.wvalue, csr_req.wmask, crmd_wmask);
                end
                csr_prmd: begin
                    prmd <= blend(prmd, csr_req.wvalue, csr_req.wmask, prmd_wmask);
                end
                csr_estat: begin
                    estat <= blend(estat, csr_req.wvalue, csr_req.wmask, estat_wmask);
                end
                csr_era: begin
                    era <= blend(era, csr_req.wvalue, csr_req.wmask, era_wmask);
                end
                csr_badv: begin
                    badv <= blend(badv, csr_req.wvalue, csr_req.wmask, badv_wmask);
                end
                csr_eentry: begin
                    eentry <= blend(eentry, csr_req.wvalue, csr_req.wmask, eentry_wmask);
                end
                csr_save0: begin
                    save0 <= blend(save0, csr_req.wvalue, csr_req.wmask, save_wmask);
                end
                csr_save1: begin
                    save1 <= blend(save1, csr_req.wvalue, csr_req.wmask, save_wmask);
                end
                csr_save2: begin
                    save2 <= blend(save2, csr_req.wvalue, csr_req.wmask, save_wmask);
                end
                csr_save3: begin
                    save3 <= blend(save3, csr_req.wvalue, csr_req.wmask, save_wmask);
                end
                default: begin
                    // unsupported number, write is lost
                end
            endcase
        end
    end

    // read returns the value before this cycle's write
    always_comb begin
        case (csr_req.num)
            csr_crmd:   csr_rvalue = crmd;
            csr_prmd:   csr_rvalue = prmd;
            csr_estat:  csr_rvalue = estat;
            csr_era:    csr_rvalue = era;
            csr_badv:   csr_rvalue = badv;
            csr_eentry: csr_rvalue = eentry;
            csr_save0:  csr_rvalue = save0;
            csr_save1:  csr_rvalue = save1;
            csr_save2:  csr_rvalue = save2;
            csr_save3:  csr_rvalue = save3;
            default:    csr_rvalue = '0;
        endcase
    end

    assign redirect_pc = wb_event.ex ? eentry : era;

    // writeback gates csr writes off for faulting items
    a_no_csr_write_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        !(csr_req.we && wb_event.ex));

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`default_nettype none

module wb_stage import wb_pkg::*; (
    input  wire              clk,
    input  wire              resetn,

    output logic             wb_allowin,
    input  wire              mem_wb_valid,
    input  wire mem_wb_bus_t mem_wb_bus,

    output wb_fwd_t          wb_id_bus,

    output csr_req_t         csr_req,
    input  wire [xlen-1:0]   csr_rvalue,
    output wb_event_t        wb_event,
    input  wire [xlen-1:0]   redirect_pc,

    output logic             rf_we,
    output logic [4:0]       rf_waddr,
    output logic [xlen-1:0]  rf_wdata,

    output trace_t           debug_trace,
    output logic             flush,
    output logic [xlen-1:0]  flush_pc
);

    logic            wb_valid;
    mem_wb_bus_t     wb_item;
    logic            wb_ex;
    logic            wb_ertn;
    logic [xlen-1:0] wb_wdata;

    assign wb_allowin = 1'b1;  // never stalls

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush) begin
            wb_valid <= 1'b0;  // item offered this cycle is dropped
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin && !flush) begin
            wb_item <= mem_wb_bus;
        end
    end

    assign wb_ex    = wb_valid & wb_item.ex;
    assign wb_ertn  = wb_valid & wb_item.ertn;
    assign flush    = wb_ex | wb_ertn;
    assign flush_pc = redirect_pc;  // eentry or era, picked by csr file

    // exchange also reads the old value
    always_comb begin
        csr_req.num    = wb_item.csr_num;
        csr_req.re     = wb_valid & (wb_item.csr_re | wb_item.csr_we);
        csr_req.we     = wb_valid & wb_item.csr_we & ~wb_item.ex & ~wb_item.ertn;
        csr_req.wvalue = wb_item.csr_wvalue;
        csr_req.wmask  = wb_item.csr_wmask;
    end

    always_comb begin
        wb_event.ex         = wb_ex;
        wb_event.ertn       = wb_ertn;
        wb_event.pc         = wb_item.pc;
        wb_event.ecode      = wb_item.ecode;
        wb_event.esubcode   = wb_item.esubcode;
        wb_event.wrong_addr = wb_item.wrong_addr;
    end

    assign wb_wdata = csr_req.re ? csr_rvalue : wb_item.final_result;

    assign rf_we    = wb_valid & wb_item.gr_we & ~wb_item.ex;
    assign rf_waddr = wb_item.dest;
    assign rf_wdata = wb_wdata;

    always_comb begin
        wb_id_bus.rf_we    = rf_we;
        wb_id_bus.rf_waddr = rf_waddr;
        wb_id_bus.rf_wdata = wb_wdata;
        wb_id_bus.csr_re   = csr_req.re;
    end

    always_comb begin
        debug_trace.pc       = wb_item.pc;
        debug_trace.rf_we    = {4{rf_we}};
        debug_trace.rf_wnum  = wb_item.dest;
        debug_trace.rf_wdata = wb_wdata;
    end

    // a faulting item never reaches the register file
    a_no_rf_write_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        mem_wb_valid && wb_allowin && !flush && mem_wb_bus.ex |=> !rf_we);

    // stage empties right after a flush
    a_flush_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !flush);

endmodule

`default_nettype wire

/* src/wb_backend.sv */
`default_nettype none

module wb_backend import wb_pkg::*; (
    input  wire              clk,
    input  wire              resetn,

    input  wire              mem_wb_valid,
    input  wire mem_wb_bus_t mem_wb_bus,
    output logic             wb_allowin,

    output wb_fwd_t          wb_id_bus,

    input  wire [4:0]        rd_addr1,
    input  wire [4:0]        rd_addr2,
    output logic [xlen-1:0]  rd_data1,
    output logic [xlen-1:0]  rd_data2,

    output trace_t           debug_trace,
    output logic             flush,
    output logic [xlen-1:0]  flush_pc
);

    csr_req_t        csr_req;
    wb_event_t       wb_event;
    logic [xlen-1:0] csr_rvalue;
    logic [xlen-1:0] redirect_pc;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    wb_stage wb_stage0 (
        .clk          (clk),
        .resetn       (resetn),
        .wb_allowin   (wb_allowin),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb_bus   (mem_wb_bus),
        .wb_id_bus    (wb_id_bus),
        .csr_req      (csr_req),
        .csr_rvalue   (csr_rvalue),
        .wb_event     (wb_event),
        .redirect_pc  (redirect_pc),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .debug_trace  (debug_trace),
        .flush        (flush),
        .flush_pc     (flush_pc)
    );

    csr_file csr_file0 (
        .clk         (clk),
        .resetn      (resetn),
        .csr_req     (csr_req),
        .wb_event    (wb_event),
        .csr_rvalue  (csr_rvalue),
        .redirect_pc (redirect_pc)
    );

    reg_file reg_file0 (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rd_addr1),
        .rdata1 (rd_data1),
        .raddr2 (rd_addr2),
        .rdata2 (rd_data2)
    );

endmodule

`default_nettype wire

/* tb/tb_wb_backend.sv */
`default_nettype none

module tb_wb_backend import wb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_init   = 31;
    localparam int n_rand   = 150;
    localparam int n_csr    = 40;
    localparam int n_exc    = 8;
    localparam int n_ertn   = 8;
    localparam int n_cycles = 7 + n_init + n_rand + 2 * 35 + 2 * n_csr + 8 * n_exc + 5 * n_ertn;
    localparam int margin   = 100;

    // last entry is a number the csr file does not implement
    localparam logic [csr_num_w-1:0] csr_list [0:10] = '{csr_crmd, csr_prmd, csr_estat,
        csr_era, csr_badv, csr_eentry, csr_save0, csr_save1, csr_save2, csr_save3, 14'h100};
    localparam logic [xlen-1:0] wmask_list [0:15] = '{crmd_wmask, prmd_wmask, estat_wmask,
        era_wmask, badv_wmask, eentry_wmask, save_wmask, save_wmask, save_wmask, save_wmask,
        '0, '0, '0, '0, '0, '0};
    localparam logic [5:0] ecode_list [0:3] = '{ecode_sys, ecode_adef, ecode_ale, ecode_ine};

    typedef struct packed {
        trace_t          tr;
        wb_fwd_t         fwd;
        logic            fl;
        logic [xlen-1:0] fpc;
    } expect_t;

    logic            clk;
    logic            resetn;
    logic            mem_wb_valid;
    mem_wb_bus_t     mem_wb_bus;
    logic            wb_allowin;
    wb_fwd_t         wb_id_bus;
    logic [4:0]      rd_addr1;
    logic [4:0]      rd_addr2;
    logic [xlen-1:0] rd_data1;
    logic [xlen-1:0] rd_data2;
    trace_t          debug_trace;
    logic            flush;
    logic [xlen-1:0] flush_pc;

    integer          seed = 23553;
    logic [xlen-1:0] sh_gpr [0:31];
    logic [xlen-1:0] sh_csr [0:15];  // slot 15 = unsupported, stays zero
    expect_t         exp_q [$];
    int              n_trace_err = 0;
    int              n_fwd_err   = 0;
    int              n_flush_err = 0;
    int              n_rdata_err = 0;
    int              n_other_err = 0;

    wb_backend dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [xlen-1:0] rnd32();
        logic [xlen-1:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic [3:0] csr_slot(input logic [csr_num_w-1:0] num);
        logic [3:0] s;
        s = 4'd15;
        for (logic [3:0] i = 4'd0; i < 4'd10; i++) begin
            if (num == csr_list[i]) begin
                s = i;
            end
        end
        return s;
    endfunction

    // expected retire of one item, shadows move on in program order
    function automatic trace_t wb_expect(input mem_wb_bus_t it, output logic fl,
                                         output logic [xlen-1:0] fpc);
        trace_t          tr;
        logic [3:0]      slot;
        logic [xlen-1:0] old_v;
        logic [xlen-1:0] m;
        logic            we;
        slot        = csr_slot(it.csr_num);
        old_v       = sh_csr[slot];
        fl          = it.ex | it.ertn;
        fpc         = it.ex ? sh_csr[5] : sh_csr[3];  // eentry or era
        we          = it.gr_we & ~it.ex;
        tr.pc       = it.pc;
        tr.rf_we    = {4{we}};
        tr.rf_wnum  = it.dest;
        tr.rf_wdata = (it.csr_re | it.csr_we) ? old_v : it.final_result;
        if (it.ex) begin
            sh_csr[1][prmd_pplv_lsb +: plv_w] = sh_csr[0][crmd_plv_lsb +: plv_w];
            sh_csr[1][prmd_pie_bit]           = sh_csr[0][crmd_ie_bit];
            sh_csr[0][crmd_plv_lsb +: plv_w]  = '0;
            sh_csr[0][crmd_ie_bit]            = 1'b0;
            sh_csr[3]                         = it.pc;
            sh_csr[2][estat_ecode_lsb +: ecode_w]       = it.ecode;
            sh_csr[2][estat_esubcode_lsb +: esubcode_w] = it.esubcode;
            if (it.ecode == ecode_adef || it.ecode == ecode_ale) begin
                sh_csr[4] = it.wrong_addr;
            end
        end else if (it.ertn) begin
            sh_csr[0][crmd_plv_lsb +: plv_w] = sh_csr[1][prmd_pplv_lsb +: plv_w];
            sh_csr[0][crmd_ie_bit]           = sh_csr[1][prmd_pie_bit];
        end else if (it.csr_we) begin
            m = it.csr_wmask & wmask_list[slot];
            sh_csr[slot] = (old_v & ~m) | (it.csr_wvalue & m);
        end
        if (we && it.dest != 5'd0) begin
            sh_gpr[it.dest] = tr.rf_wdata;
        end
        return tr;
    endfunction

    function automatic mem_wb_bus_t rand_item();
        mem_wb_bus_t     it;
        logic [xlen-1:0] r;
        it              = '0;
        r               = rnd32();
        it.gr_we        = 1'b1;
        it.pc           = {r[31:2], 2'b00};
        it.inst         = rnd32();
        it.final_result = rnd32();
        r               = rnd32();
        it.dest         = r[4:0];
        return it;
    endfunction

    function automatic mem_wb_bus_t csr_op(input logic [csr_num_w-1:0] num, input logic re,
                                           input logic we, input logic [xlen-1:0] wvalue,
                                           input logic [xlen-1:0] wmask);
        mem_wb_bus_t it;
        it            = rand_item();
        it.csr_num    = num;
        it.csr_re     = re;
        it.csr_we     = we;
        it.csr_wvalue = wvalue;
        it.csr_wmask  = wmask;
        return it;
    endfunction

    task automatic check_trace(input trace_t got, input trace_t want);
        if (got !== want) begin
            n_trace_err++;
            $display("Mismatch at %0t: trace pc=%h we=%h r%0d=%h, expected pc=%h we=%h r%0d=%h",
                     $time, got.pc, got.rf_we, got.rf_wnum, got.rf_wdata,
                     want.pc, want.rf_we, want.rf_wnum, want.rf_wdata);
        end
    endtask

    task automatic check_fwd(input wb_fwd_t got, input wb_fwd_t want);
        if (got !== want) begin
            n_fwd_err++;
            $display("Mismatch at %0t: forward bus %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_flush(input logic got_fl, input logic [xlen-1:0] got_pc,
                               input logic want_fl, input logic [xlen-1:0] want_pc);
        if (got_fl !== want_fl || (want_fl && got_pc !== want_pc)) begin
            n_flush_err++;
            $display("Mismatch at %0t: flush %b to %h, expected %b to %h",
                     $time, got_fl, got_pc, want_fl, want_pc);
        end
    endtask

    task automatic check_rdata(input logic [4:0] addr, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] want);
        if (got !== want) begin
            n_rdata_err++;
            $display("Mismatch at %0t: r%0d reads %h, expected %h", $time, addr, got, want);
        end
    endtask

    task automatic drive(input logic valid, input mem_wb_bus_t it, input logic model);
        expect_t         e;
        logic            fl;
        logic [xlen-1:0] fpc;
        @(posedge clk);
        #2;
        mem_wb_valid = valid;
        mem_wb_bus   = it;
        if (model) begin
            e.tr           = wb_expect(it, fl, fpc);
            e.fl           = fl;
            e.fpc          = fpc;
            e.fwd.rf_we    = e.tr.rf_we[0];
            e.fwd.rf_waddr = it.dest;
            e.fwd.rf_wdata = e.tr.rf_wdata;
            e.fwd.csr_re   = it.csr_re | it.csr_we;
            if (e.tr.rf_we != 4'b0 || fl) begin
                exp_q.push_back(e);
            end
        end
    endtask

    // pipeline drains first, then both ports sweep all registers
    task automatic read_all();
        repeat (3) drive(1'b0, rand_item(), 1'b0);
        for (int i = 0; i < 32; i++) begin
            drive(1'b0, rand_item(), 1'b0);
            rd_addr1 = 5'(i);
            rd_addr2 = 5'(31 - i);
            @(negedge clk);
            check_rdata(rd_addr1, rd_data1, sh_gpr[rd_addr1]);
            check_rdata(rd_addr2, rd_data2, sh_gpr[rd_addr2]);
        end
    endtask

    // mid-cycle sample, only when something retires or flushes
    always @(negedge clk) begin
        expect_t e;
        if (resetn === 1'b1) begin
            if (wb_allowin !== 1'b1) begin
                n_other_err++;
                $display("%0t: wb_allowin dropped low", $time);
            end
            if (debug_trace.rf_we !== 4'b0 || flush !== 1'b0) begin
                if (exp_q.size() == 0) begin
                    n_other_err++;
                    $display("%0t: register write or flush with no item expected", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_trace(debug_trace, e.tr);
                    check_fwd(wb_id_bus, e.fwd);
                    check_flush(flush, flush_pc, e.fl, e.fpc);
                end
            end
        end
    end

    initial begin
        mem_wb_bus_t          it;
        logic [xlen-1:0]      r;
        logic [csr_num_w-1:0] num;
        resetn       = 1'b0;
        mem_wb_valid = 1'b0;
        mem_wb_bus   = '0;
        rd_addr1     = 5'd0;
        rd_addr2     = 5'd0;
        sh_gpr       = '{default: '0};
        sh_csr       = '{default: '0};
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;

        for (int i = 1; i < 32; i++) begin  // register file has no reset
            it      = rand_item();
            it.dest = 5'(i);
            drive(1'b1, it, 1'b1);
        end
        for (int n = 0; n < n_rand; n++) begin
            r        = rnd32();
            it       = rand_item();
            it.gr_we = r[2] | r[3];
            drive(r[1:0] != 2'b00, it, r[1:0] != 2'b00);
        end
        read_all();

        // read, write or exchange, then a plain read of the same csr
        for (int n = 0; n < n_csr; n++) begin
            r   = rnd32();
            num = csr_list[4'(r[7:4] % 11)];
            drive(1'b1, csr_op(num, r[0], r[1] | ~r[0], rnd32(), r[2] ? '1 : rnd32()), 1'b1);
            drive(1'b1, csr_op(num, 1'b1, 1'b0, '0, '0), 1'b1);
        end

        for (int n = 0; n < n_exc; n++) begin
            drive(1'b1, csr_op(csr_crmd, 1'b0, 1'b1, rnd32(), '1), 1'b1);
            drive(1'b1, csr_op(csr_eentry, 1'b0, 1'b1, rnd32(), '1), 1'b1);
            r             = rnd32();
            it            = rand_item();
            it.gr_we      = r[0];
            it.ex         = 1'b1;
            it.ecode      = ecode_list[r[3:2]];
            it.esubcode   = r[12:4];
            it.wrong_addr = rnd32();
            drive(1'b1, it, 1'b1);
            drive(1'b1, rand_item(), 1'b0);  // lost to the flush
            drive(1'b1, csr_op(csr_era, 1'b1, 1'b0, '0, '0), 1'b1);
            drive(1'b1, csr_op(csr_estat, 1'b1, 1'b0, '0, '0), 1'b1);
            drive(1'b1, csr_op(csr_badv, 1'b1, 1'b0, '0, '0), 1'b1);
            drive(1'b1, csr_op(csr_prmd, 1'b1, 1'b0, '0, '0), 1'b1);
        end

        for (int n = 0; n < n_ertn; n++) begin
            drive(1'b1, csr_op(csr_prmd, 1'b0, 1'b1, rnd32(), '1), 1'b1);
            drive(1'b1, csr_op(csr_era, 1'b0, 1'b1, rnd32(), '1), 1'b1);
            it       = rand_item();
            it.gr_we = 1'b0;
            it.ertn  = 1'b1;
            drive(1'b1, it, 1'b1);
            drive(1'b1, rand_item(), 1'b0);
            drive(1'b1, csr_op(csr_crmd, 1'b1, 1'b0, '0, '0), 1'b1);
        end
        read_all();
        repeat (3) drive(1'b0, rand_item(), 1'b0);

        if (exp_q.size() != 0) begin
            n_other_err++;
            $display("%0d expected retirements never appeared", exp_q.size());
        end
        $display("errors: trace %0d, forward %0d, flush %0d, read %0d, other %0d",
                 n_trace_err, n_fwd_err, n_flush_err, n_rdata_err, n_other_err);
        if (n_trace_err + n_fwd_err + n_flush_err + n_rdata_err + n_other_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #((n_cycles + margin) * 20);
        $display("watchdog expired after %0d cycles, stimulus never finished", n_cycles + margin);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* wb_backend.f */
+incdir+include
src/wb_pkg.sv
src/reg_file.sv
src/csr_file.sv
src/wb_stage.sv
src/wb_backend.sv
tb/tb_wb_backend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the wb_backend testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_wb_backend -f wb_backend.f -o tb_wb_backend \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_wb_backend > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
